// File: dot_stream.f
+incdir+.
dot_stream_pkg.sv
handshake_buffer.sv
dot_stream_mac.sv
dot_stream_top.sv
dot_stream_assert.sv
dot_stream_check.sv
dot_stream_tb.sv

// File: Makefile
# Verilator build and run of the dot_stream testbench

TOP := dot_stream_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f dot_stream.f -o sim
	./obj_dir/sim > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q 'Test failures found' sim.log; then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q 'All tests passed!' sim.log; then echo "Simulation did not finish"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf obj_dir sim.log

// File: dot_stream_tb.sv
`timescale 1ns/10ps

`include "dot_stream_defs.svh"

// Testbench for the streaming dot-product joiner
// Two driver processes walk the stimulus table independently, one per input stream
module dot_stream_tb;

   import dot_stream_pkg::*;

   // Extra cycles allowed for random back-pressure on the result stream
   localparam int STALL_MARGIN = 200;

   // One row is the A beat and the B beat of one pair
   typedef struct packed {
      logic [`DOT_TAG_W-1:0]           tag;
      logic signed [`DOT_SAMPLE_W-1:0] sample;
      logic signed [`DOT_COEF_W-1:0]   coef;
      logic                            last;
      int                              a_delay;
      int                              b_delay;
      logic                            stall;
   } stim_row_t;

   logic                            clk_i = 1'b0;
   logic                            rst_i;
   logic                            a_valid_i;
   logic                            a_ready_o;
   logic [`DOT_TAG_W-1:0]           a_tag_i;
   logic signed [`DOT_SAMPLE_W-1:0] a_sample_i;
   logic                            b_valid_i;
   logic                            b_ready_o;
   logic signed [`DOT_COEF_W-1:0]   b_coef_i;
   logic                            b_last_i;
   logic                            res_valid_o;
   logic                            res_ready_i;
   logic [`DOT_TAG_W-1:0]           res_tag_o;
   acc_t                            res_acc_o;
   logic                            res_last_o;

   stim_row_t   rows[$];
   logic [15:0] burst_mask;
   logic        done;
   int          seed = 68;
   int          rnd;
   int          cycle_count = 0;
   int          cycle_limit = 0;
   int          result_count;
   int          test_count;
   int          failed_test_count;
   int          error_count;
   int          assert_fails;

   always #5 clk_i = ~clk_i;

   dot_stream_top dut_i (.*);

   dot_stream_check scoreboard (
      .clk_i               (clk_i),
      .rst_i               (rst_i),
      .a_valid_i           (a_valid_i),
      .a_ready_i           (a_ready_o),
      .a_tag_i             (a_tag_i),
      .a_sample_i          (a_sample_i),
      .b_valid_i           (b_valid_i),
      .b_ready_i           (b_ready_o),
      .b_coef_i            (b_coef_i),
      .b_last_i            (b_last_i),
      .res_valid_i         (res_valid_o),
      .res_ready_i         (res_ready_i),
      .res_tag_i           (res_tag_o),
      .res_acc_i           (res_acc_o),
      .res_last_i          (res_last_o),
      .burst_mask_i        (burst_mask),
      .done_i              (done),
      .result_count_o      (result_count),
      .test_count_o        (test_count),
      .failed_test_count_o (failed_test_count),
      .error_count_o       (error_count)
   );

   task automatic add_row(input int tag, input int sample, input int coef, input bit last,
                          input int a_delay, input int b_delay, input bit stall);
      stim_row_t r;
      r.tag     = tag[`DOT_TAG_W-1:0];
      r.sample  = sample[`DOT_SAMPLE_W-1:0];
      r.coef    = coef[`DOT_COEF_W-1:0];
      r.last    = last;
      r.a_delay = a_delay;
      r.b_delay = b_delay;
      r.stall   = stall;
      rows.push_back(r);
   endtask

   // Vectors without delays or stalls must stream, and the timeout scales with the table
   task automatic prepare_run();
      int max_delay;
      int t;
      bit burst;
      max_delay  = 0;
      t          = 0;
      burst      = 1'b1;
      burst_mask = '0;
      foreach (rows[i]) begin
         if (rows[i].a_delay > max_delay) begin
            max_delay = rows[i].a_delay;
         end
         if (rows[i].b_delay > max_delay) begin
            max_delay = rows[i].b_delay;
         end
         burst = burst && rows[i].a_delay == 0 && rows[i].b_delay == 0 && !rows[i].stall;
         if (rows[i].last) begin
            burst_mask[t] = burst;
            t++;
            burst = 1'b1;
         end
      end
      cycle_limit = rows.size() * (max_delay + 4) + STALL_MARGIN;
   endtask

   // Each beat waits its start delay, then stays offered until the DUT takes it
   task automatic drive_a();
      for (int i = 0; i < rows.size(); i++) begin
         repeat (rows[i].a_delay) @(negedge clk_i);
         a_valid_i  = 1'b1;
         a_tag_i    = rows[i].tag;
         a_sample_i = rows[i].sample;
         @(posedge clk_i);
         while (!a_ready_o) @(posedge clk_i);
         @(negedge clk_i);
         a_valid_i = 1'b0;
      end
   endtask

   task automatic drive_b();
      for (int i = 0; i < rows.size(); i++) begin
         repeat (rows[i].b_delay) @(negedge clk_i);
         b_valid_i = 1'b1;
         b_coef_i  = rows[i].coef;
         b_last_i  = rows[i].last;
         @(posedge clk_i);
         while (!b_ready_o) @(posedge clk_i);
         @(negedge clk_i);
         b_valid_i = 1'b0;
      end
   endtask

   // Random back-pressure applies while the pending result belongs to a stall row
   always @(negedge clk_i) begin
      if (!rst_i && result_count < rows.size() && rows[result_count].stall) begin
         rnd         = $random(seed);
         res_ready_i = rnd[0];
      end else begin
         res_ready_i = 1'b1;
      end
   end

   always @(posedge clk_i) begin
      cycle_count++;
      if (cycle_count >= cycle_limit) begin
         $display("Timed out after %0d cycles with %0d of %0d results received",
                  cycle_count, result_count, rows.size());
         $display("Test failures found");
         $finish;
      end
   end

   initial begin
      rst_i       = 1'b1;
      a_valid_i   = 1'b0;
      a_tag_i     = '0;
      a_sample_i  = '0;
      b_valid_i   = 1'b0;
      b_coef_i    = '0;
      b_last_i    = 1'b0;
      res_ready_i = 1'b1;
      done        = 1'b0;
      // Tag, sample, coefficient, last, A delay, B delay, stall
      // Single-element vectors
      add_row(1, 3, 5, 1, 0, 0, 0);
      add_row(2, -7, 9, 1, 1, 0, 0);
      add_row(3, 32767, -32768, 1, 0, 2, 0);
      // Running sums, then a restart right after a last
      add_row(4, 100, 2, 0, 0, 0, 0);
      add_row(5, -200, 3, 0, 1, 1, 0);
      add_row(6, 300, -4, 1, 0, 2, 0);
      add_row(7, -1, 1, 0, 0, 0, 0);
      add_row(8, 2, 2, 1, 0, 0, 0);
      // A ahead of B, then B ahead of A
      add_row(9, 11, -3, 0, 0, 3, 0);
      add_row(10, 12, 4, 0, 0, 3, 0);
      add_row(11, -13, 5, 1, 0, 3, 0);
      add_row(12, 21, 6, 0, 3, 0, 0);
      add_row(13, -22, 7, 0, 3, 0, 0);
      add_row(14, 23, -8, 1, 3, 0, 0);
      // Back-pressure with sums that pass 32 bits
      add_row(15, -32768, -32768, 0, 0, 0, 1);
      add_row(0, -32768, -32768, 0, 0, 0, 1);
      add_row(1, 1000, -999, 0, 0, 0, 1);
      add_row(2, -5, 5, 1, 0, 0, 1);
      // Continuous streaming
      add_row(3, 1, 1, 0, 0, 0, 0);
      add_row(4, 2, -2, 0, 0, 0, 0);
      add_row(5, 3, 3, 0, 0, 0, 0);
      add_row(6, -4, 4, 0, 0, 0, 0);
      add_row(7, 5, 5, 1, 0, 0, 0);
      prepare_run();
      repeat (3) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b0;
      fork
         drive_a();
         drive_b();
      join_none
      wait (result_count == rows.size());
      // A few idle cycles would expose any extra result
      repeat (4) @(negedge clk_i);
      done = 1'b1;
      repeat (2) @(negedge clk_i);
      assert_fails = dut_i.protocol_assert.fail_count;
      $display("%0d tests, %0d failed, %0d results, %0d errors, %0d assertion failures",
               test_count, failed_test_count, result_count, error_count, assert_fails);
      if (error_count == 0 && assert_fails == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// File: dot_stream_check.sv
`timescale 1ns/10ps

`include "dot_stream_defs.svh"

// Scoreboard for dot_stream_top
// A and B transfers at the top ports go into queues and are paired in arrival order
module dot_stream_check (
   input  logic                           clk_i,
   input  logic                           rst_i,
   input  logic                           a_valid_i,
   input  logic                           a_ready_i,
   input  logic [`DOT_TAG_W-1:0]          a_tag_i,
   input  logic signed [`DOT_SAMPLE_W-1:0] a_sample_i,
   input  logic                           b_valid_i,
   input  logic                           b_ready_i,
   input  logic signed [`DOT_COEF_W-1:0]  b_coef_i,
   input  logic                           b_last_i,
   input  logic                           res_valid_i,
   input  logic                           res_ready_i,
   input  logic [`DOT_TAG_W-1:0]          res_tag_i,
   input  dot_stream_pkg::acc_t           res_acc_i,
   input  logic                           res_last_i,
   input  logic [15:0]                    burst_mask_i,
   input  logic                           done_i,
   output int                             result_count_o,
   output int                             test_count_o,
   output int                             failed_test_count_o,
   output int                             error_count_o
);

   import dot_stream_pkg::*;

   // Beats seen at the top, waiting for their result
   logic [`DOT_TAG_W-1:0]           a_tag_q[$];
   logic signed [`DOT_SAMPLE_W-1:0] a_sample_q[$];
   logic signed [`DOT_COEF_W-1:0]   b_coef_q[$];
   logic                            b_last_q[$];

   // Reference running sum, restarted on the pair after a last
   acc_t exp_acc;
   logic restart;

   // Per-vector bookkeeping
   int   cycle;
   int   last_res_cycle;
   int   vec_results;
   int   vec_errors;
   logic reset_checked;
   logic final_checked;

   task automatic count_error();
      error_count_o++;
      vec_errors++;
   endtask

   task automatic check_result();
      logic [`DOT_TAG_W-1:0] tag;
      acc_t                  sample_x;
      acc_t                  coef_x;
      logic                  last;
      if (a_tag_q.size() == 0 || b_coef_q.size() == 0) begin
         $display("Result at %0t arrived without a matching A and B beat", $time);
         count_error();
         return;
      end
      tag      = a_tag_q.pop_front();
      sample_x = acc_t'(a_sample_q.pop_front());
      coef_x   = acc_t'(b_coef_q.pop_front());
      last     = b_last_q.pop_front();
      // Sample and coefficient are sign-extended before the product
      exp_acc  = restart ? sample_x * coef_x : exp_acc + sample_x * coef_x;
      restart  = last;
      if (res_tag_i !== tag || res_acc_i !== exp_acc || res_last_i !== last) begin
         $display("ERR %0t: result %0d got tag %0h sum %0d last %0b, expected %0h %0d %0b",
                  $time, result_count_o, res_tag_i, res_acc_i, res_last_i,
                  tag, exp_acc, last);
         count_error();
      end
      // Streaming vectors must deliver one result per cycle after their first
      if (burst_mask_i[test_count_o[3:0]] && vec_results > 0 && cycle != last_res_cycle + 1) begin
         $display("Test %0d: result at %0t came %0d cycles after the previous one",
                  test_count_o, $time, cycle - last_res_cycle);
         count_error();
      end
      last_res_cycle = cycle;
      vec_results++;
      result_count_o++;
      if (last) begin
         if (vec_errors == 0) begin
            $display("Test %0d: PASS, %0d results", test_count_o, vec_results);
         end else begin
            $display("Test %0d: FAIL, %0d errors", test_count_o, vec_errors);
            failed_test_count_o++;
         end
         test_count_o++;
         vec_results = 0;
         vec_errors  = 0;
      end
   endtask

   always @(posedge clk_i) begin
      if (rst_i) begin
         result_count_o      = 0;
         test_count_o        = 0;
         failed_test_count_o = 0;
         error_count_o       = 0;
         restart             = 1'b1;
         exp_acc             = '0;
         cycle               = 0;
         last_res_cycle      = 0;
         vec_results         = 0;
         vec_errors          = 0;
         reset_checked       = 1'b0;
         final_checked       = 1'b0;
      end else begin
         cycle++;
         // First edge out of reset: no result yet, both inputs open
         if (!reset_checked) begin
            reset_checked = 1'b1;
            if (res_valid_i !== 1'b0 || a_ready_i !== 1'b1 || b_ready_i !== 1'b1) begin
               $display("ERR %0t: after reset got res_valid %b a_ready %b b_ready %b",
                        $time, res_valid_i, a_ready_i, b_ready_i);
               count_error();
            end
         end
         // Results are taken before new beats so an empty queue means a spurious result
         if (res_valid_i && res_ready_i) begin
            check_result();
         end
         if (a_valid_i && a_ready_i) begin
            a_tag_q.push_back(a_tag_i);
            a_sample_q.push_back(a_sample_i);
         end
         if (b_valid_i && b_ready_i) begin
            b_coef_q.push_back(b_coef_i);
            b_last_q.push_back(b_last_i);
         end
         // Every pair sent must have produced exactly one result
         if (done_i && !final_checked) begin
            final_checked = 1'b1;
            if (a_tag_q.size() != 0 || b_coef_q.size() != 0) begin
               $display("%0d A beats and %0d B beats never produced a result",
                        a_tag_q.size(), b_coef_q.size());
               count_error();
            end
         end
      end
   end

endmodule

// File: dot_stream_assert.sv
`timescale 1ns/10ps

`include "dot_stream_defs.svh"

// Protocol assertions on dot_stream_top, attached with bind below
module dot_stream_assert (
   input logic                  clk_i,
   input logic                  rst_i,
   input logic                  a_valid_i,
   input logic                  a_ready_i,
   input logic                  b_valid_i,
   input logic                  b_ready_i,
   input logic                  a_buf_valid_i,
   input logic                  a_buf_ready_i,
   input logic                  b_buf_valid_i,
   input logic                  b_buf_ready_i,
   input logic                  res_valid_i,
   input logic                  res_ready_i,
   input logic [`DOT_TAG_W-1:0] res_tag_i,
   input dot_stream_pkg::acc_t  res_acc_i,
   input logic                  res_last_i
);

   // Failed assertions so far, collected by the testbench at the end of the run
   int fail_count = 0;

   // A result that waits for ready holds its value
   assert property (@(posedge clk_i) disable iff (rst_i)
      res_valid_i && !res_ready_i |=> res_valid_i && $stable(res_tag_i)
         && $stable(res_acc_i) && $stable(res_last_i))
   else begin
      $error("Result changed while it waited for ready");
      fail_count++;
   end

   // Input readies are always driven once reset is over
   assert property (@(posedge clk_i) disable iff (rst_i)
      !$isunknown({a_ready_i, b_ready_i}))
   else begin
      $error("Input ready is unknown");
      fail_count++;
   end

   // A beat taken at the top lands in an empty or draining buffer, so none is overwritten
   assert property (@(posedge clk_i) disable iff (rst_i)
      !(a_valid_i && a_ready_i && a_buf_valid_i && !a_buf_ready_i)
         && !(b_valid_i && b_ready_i && b_buf_valid_i && !b_buf_ready_i))
   else begin
      $error("Beat taken while its buffer still held an undelivered beat");
      fail_count++;
   end

   // No result is pending in the first cycle after reset
   assert property (@(posedge clk_i) $fell(rst_i) |-> !res_valid_i)
   else begin
      $error("Result valid right after reset");
      fail_count++;
   end

endmodule

bind dot_stream_top dot_stream_assert protocol_assert (
   .clk_i         (clk_i),
   .rst_i         (rst_i),
   .a_valid_i     (a_valid_i),
   .a_ready_i     (a_ready_o),
   .b_valid_i     (b_valid_i),
   .b_ready_i     (b_ready_o),
   .a_buf_valid_i (a_buf_valid),
   .a_buf_ready_i (a_buf_ready),
   .b_buf_valid_i (b_buf_valid),
   .b_buf_ready_i (b_buf_ready),
   .res_valid_i   (res_valid_o),
   .res_ready_i   (res_ready_i),
   .res_tag_i     (res_tag_o),
   .res_acc_i     (res_acc_o),
   .res_last_i    (res_last_o)
);

// File: dot_stream_top.sv
`timescale 1ns/10ps

`include "dot_stream_defs.svh"

// Streaming dot-product joiner
// Each input stream goes through its own one-entry buffer, then the joiner
// pairs the buffered beats and produces running sums
module dot_stream_top (
   input  logic                           clk_i,
   input  logic                           rst_i,

   // Stream A with tagged samples
   input  logic                           a_valid_i,
   output logic                           a_ready_o,
   input  logic [`DOT_TAG_W-1:0]          a_tag_i,
   input  logic signed [`DOT_SAMPLE_W-1:0] a_sample_i,

   // Stream B with coefficients
   input  logic                           b_valid_i,
   output logic                           b_ready_o,
   input  logic signed [`DOT_COEF_W-1:0]  b_coef_i,
   input  logic                           b_last_i,

   // Result stream
   output logic                           res_valid_o,
   input  logic                           res_ready_i,
   output logic [`DOT_TAG_W-1:0]          res_tag_o,
   output dot_stream_pkg::acc_t           res_acc_o,
   output logic                           res_last_o
);

   import dot_stream_pkg::*;

   // Beats entering the buffers
   sample_beat_t a_in_beat;
   coef_beat_t   b_in_beat;

   // Buffered beats on their way to the joiner
   sample_beat_t a_buf_beat;
   coef_beat_t   b_buf_beat;
   logic         a_buf_valid;
   logic         a_buf_ready;
   logic         b_buf_valid;
   logic         b_buf_ready;

   // Loose fields are packed into one payload per stream
   assign a_in_beat.tag    = a_tag_i;
   assign a_in_beat.sample = a_sample_i;
   assign b_in_beat.coef   = b_coef_i;
   assign b_in_beat.last   = b_last_i;

   handshake_buffer #(
      .payload_t (sample_beat_t)
   ) buf_a (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .in_valid_i  (a_valid_i),
      .in_ready_o  (a_ready_o),
      .in_data_i   (a_in_beat),
      .out_valid_o (a_buf_valid),
      .out_ready_i (a_buf_ready),
      .out_data_o  (a_buf_beat)
   );

   handshake_buffer #(
      .payload_t (coef_beat_t)
   ) buf_b (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .in_valid_i  (b_valid_i),
      .in_ready_o  (b_ready_o),
      .in_data_i   (b_in_beat),
      .out_valid_o (b_buf_valid),
      .out_ready_i (b_buf_ready),
      .out_data_o  (b_buf_beat)
   );

   // The joiner drives the result ports directly from its result register
   dot_stream_mac mac (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .a_valid_i   (a_buf_valid),
      .a_ready_o   (a_buf_ready),
      .a_beat_i    (a_buf_beat),
      .b_valid_i   (b_buf_valid),
      .b_ready_o   (b_buf_ready),
      .b_beat_i    (b_buf_beat),
      .res_valid_o (res_valid_o),
      .res_ready_i (res_ready_i),
      .res_tag_o   (res_tag_o),
      .res_acc_o   (res_acc_o),
      .res_last_o  (res_last_o)
   );

endmodule

// File: dot_stream_mac.sv
`timescale 1ns/10ps

`include "dot_stream_defs.svh"

// Multiply-accumulate joiner
// Pairs one A beat with one B beat in arrival order, multiplies them and adds
// the product to the running sum
// The sum restarts from zero on the pair after one that carried last
module dot_stream_mac (
   input  logic                        clk_i,
   input  logic                        rst_i,

   // Buffered stream A
   input  logic                        a_valid_i,
   output logic                        a_ready_o,
   input  dot_stream_pkg::sample_beat_t a_beat_i,

   // Buffered stream B
   input  logic                        b_valid_i,
   output logic                        b_ready_o,
   input  dot_stream_pkg::coef_beat_t  b_beat_i,

   // Result stream
   output logic                        res_valid_o,
   input  logic                        res_ready_i,
   output logic [`DOT_TAG_W-1:0]       res_tag_o,
   output dot_stream_pkg::acc_t        res_acc_o,
   output logic                        res_last_o
);

   import dot_stream_pkg::*;

   localparam int PROD_W = `DOT_SAMPLE_W + `DOT_COEF_W;

   // Result slot
   logic                     res_valid_q;
   logic [`DOT_TAG_W-1:0]    res_tag_q;
   acc_t                     res_acc_q;
   logic                     res_last_q;

   // Set when the next pair opens a new vector
   logic                     restart_q;

   // Pair handshake
   logic                     slot_free;
   logic                     fire;

   // Datapath
   logic signed [PROD_W-1:0] product;
   acc_t                     product_ext;
   acc_t                     acc_base;
   acc_t                     acc_next;

   // The slot can take a new result when empty or when its result leaves now
   assign slot_free = !res_valid_q || res_ready_i;

   // Both sides must be present, so A and B are always consumed together
   assign fire = a_valid_i && b_valid_i && slot_free;

   assign a_ready_o = fire;
   assign b_ready_o = fire;

   // Full-precision signed product
   assign product = $signed(a_beat_i.sample) * $signed(b_beat_i.coef);

   // Sign extension up to the accumulator width
   assign product_ext = {{(`DOT_ACC_W - PROD_W){product[PROD_W-1]}}, product};

   // The previous sum is dropped when the last pair closed a vector
   assign acc_base = restart_q ? '0 : res_acc_q;
   assign acc_next = acc_base + product_ext;

   // Control state of the result slot and the restart flag
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         res_valid_q <= 1'b0;
         restart_q   <= 1'b1;
      end else begin
         if (fire) begin
            res_valid_q <= 1'b1;
            restart_q   <= b_beat_i.last;
         end else if (res_ready_i) begin
            res_valid_q <= 1'b0;
         end
      end
   end

   // Result payload
   // The stored sum doubles as the accumulator for the next pair
   always_ff @(posedge clk_i) begin
      if (fire) begin
         res_tag_q  <= a_beat_i.tag;
         res_acc_q  <= acc_next;
         res_last_q <= b_beat_i.last;
      end
   end

   assign res_valid_o = res_valid_q;
   assign res_tag_o   = res_tag_q;
   assign res_acc_o   = res_acc_q;
   assign res_last_o  = res_last_q;

endmodule

// File: handshake_buffer.sv
`timescale 1ns/10ps

// One-entry valid/ready buffer
// Ready is not registered, so the path from out_ready_i to in_ready_o stays combinational
// The buffer asserts in_ready_o whenever it is empty, which gives a pull-style
// interface where the upstream never waits on a valid from downstream
module handshake_buffer #(
   parameter type payload_t = logic [7:0]
) (
   input  logic     clk_i,
   input  logic     rst_i,

   // Upstream side
   input  logic     in_valid_i,
   output logic     in_ready_o,
   input  payload_t in_data_i,

   // Downstream side
   output logic     out_valid_o,
   input  logic     out_ready_i,
   output payload_t out_data_o
);

   // Occupancy of the single entry
   logic     data_valid_q;

   // Stored beat
   payload_t data_q;

   // A beat enters on this cycle
   logic     load;

   // The stored beat leaves on this cycle
   logic     drain;

   assign drain = data_valid_q && out_ready_i;
   assign load  = in_valid_i && in_ready_o;

   // An empty entry can always take a beat
   // A full entry can take one only when its beat leaves in the same cycle
   // and the upstream actually offers a new one
   always_comb begin
      in_ready_o = 1'b0;
      if (!data_valid_q) begin
         in_ready_o = 1'b1;
      end
      if (in_valid_i && drain) begin
         in_ready_o = 1'b1;
      end
   end

   // A load wins over a drain, so a beat that passes through in the same
   // cycle keeps the entry full
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         data_valid_q <= 1'b0;
      end else if (load) begin
         data_valid_q <= 1'b1;
      end else if (drain) begin
         data_valid_q <= 1'b0;
      end
   end

   // Payload register, written with every accepted beat
   always_ff @(posedge clk_i) begin
      if (load) begin
         data_q <= in_data_i;
      end
   end

   assign out_valid_o = data_valid_q;
   assign out_data_o  = data_q;

endmodule

// File: dot_stream_pkg.sv
`include "dot_stream_defs.svh"

package dot_stream_pkg;

   // One beat of stream A
   // The tag rides along untouched and comes back with the matching result
   typedef struct packed {
      logic [`DOT_TAG_W-1:0]           tag;
      logic signed [`DOT_SAMPLE_W-1:0] sample;
   } sample_beat_t;

   // One beat of stream B
   // Last marks the final coefficient of a vector
   typedef struct packed {
      logic signed [`DOT_COEF_W-1:0] coef;
      logic                          last;
   } coef_beat_t;

   // Running sum of products
   typedef logic signed [`DOT_ACC_W-1:0] acc_t;

endpackage

// File: dot_stream_defs.svh
`ifndef DOT_STREAM_DEFS_SVH
`define DOT_STREAM_DEFS_SVH

// Field widths shared by the package, the RTL and the testbench

// Tag carried by every A beat and returned with its result
`define DOT_TAG_W 4

// Signed sample on stream A
`define DOT_SAMPLE_W 16

// Signed coefficient on stream B
`define DOT_COEF_W 16

// Signed running sum
// A 32-bit product plus 8 guard bits covers vectors of up to 256 elements
`define DOT_ACC_W 40

`endif
